//--- source/vdec_pkg.sv
// vector decode sizing constants, width typedefs and mode enums
`default_nettype none

package vdec_pkg;

  // vector register size and datapath width
  localparam int VLENB    = 16;
  localparam int LANES    = 2;
  // wide enough for VLMAX of 128 at SEW8 and LMUL8
  localparam int OFFSET_W = 8;

  typedef logic [31:0]         word_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [4:0]          vreg_t;
  typedef logic [4:0]          imm5_t;

  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2
  } sew_t;

  typedef enum logic [2:0] {
    LMUL1 = 3'd0,
    LMUL2 = 3'd1,
    LMUL4 = 3'd2,
    LMUL8 = 3'd3
  } lmul_t;

  // source element index for the vs2 operand
  typedef enum logic [2:0] {
    VS2_NORMAL,
    VS2_IDX_PLUS_RS1,
    VS2_IDX_PLUS_UIMM,
    VS2_IDX_PLUS_1,
    VS2_IDX_MINUS_1,
    VS2_RS1,
    VS2_UIMM,
    VS2_ZERO
  } vs2_src_t;

  // destination element index
  typedef enum logic [2:0] {
    VD_NORMAL,
    VD_ZERO,
    VD_IDX_PLUS_RS1,
    VD_IDX_PLUS_UIMM,
    VD_IDX_PLUS_1
  } vd_src_t;

  typedef enum logic [1:0] {
    WM_SAME,
    WM_WIDEN,
    WM_NARROW
  } width_mode_t;

  typedef enum logic {
    EC_IDLE,
    EC_BUSY
  } ec_state_t;

endpackage

`default_nettype wire

//--- source/vtype_csr.sv
// vector configuration register holding sew, lmul, vl and vstart
`timescale 1ns/100ps
`default_nettype none

module vtype_csr (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              cfg_wen,
  input  logic              busy,
  input  vdec_pkg::sew_t    cfg_sew,
  input  vdec_pkg::lmul_t   cfg_lmul,
  input  vdec_pkg::word_t   cfg_avl,
  input  vdec_pkg::offset_t cfg_vstart,
  output vdec_pkg::sew_t    sew,
  output vdec_pkg::lmul_t   lmul,
  output vdec_pkg::offset_t vl,
  output vdec_pkg::offset_t vstart
);

  vdec_pkg::word_t vlmax;
  vdec_pkg::word_t vl_next;

  // elements per register group for the requested config
  assign vlmax = (vdec_pkg::word_t'(vdec_pkg::VLENB) >> cfg_sew) << cfg_lmul;

  // avl clamp
  assign vl_next = (cfg_avl < vlmax) ? cfg_avl : vlmax;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sew    <= vdec_pkg::SEW8;
      lmul   <= vdec_pkg::LMUL1;
      vl     <= '0;
      vstart <= '0;
    end else if (cfg_wen && !busy) begin
      // config is frozen while a sweep is running
      sew    <= cfg_sew;
      lmul   <= cfg_lmul;
      vl     <= vl_next[vdec_pkg::OFFSET_W-1:0];
      vstart <= cfg_vstart;
    end
  end

endmodule

`default_nettype wire

//--- source/element_counter.sv
// element pair counter FSM stepping from vstart to vl
`timescale 1ns/100ps
`default_nettype none

module element_counter (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              start,
  input  logic              stall,
  input  logic              flush,
  input  vdec_pkg::offset_t vl,
  input  vdec_pkg::offset_t vstart,
  output logic              busy,
  output logic              last,
  output vdec_pkg::offset_t offset
);

  vdec_pkg::ec_state_t state;
  logic [vdec_pkg::OFFSET_W:0] offset_ahead;

  assign busy = (state == vdec_pkg::EC_BUSY);

  // one extra bit so the compare cannot wrap near the top of the range
  assign offset_ahead = {1'b0, offset} + (vdec_pkg::OFFSET_W + 1)'(vdec_pkg::LANES);
  assign last         = busy && (offset_ahead >= {1'b0, vl});

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= vdec_pkg::EC_IDLE;
      offset <= '0;
    end else if (flush) begin
      // abort the sweep, flush beats stall
      state  <= vdec_pkg::EC_IDLE;
      offset <= '0;
    end else if (!stall) begin
      case (state)
        vdec_pkg::EC_IDLE: begin
          if (start && (vstart < vl)) begin
            state  <= vdec_pkg::EC_BUSY;
            offset <= vstart;
          end
        end
        vdec_pkg::EC_BUSY: begin
          offset <= offset_ahead[vdec_pkg::OFFSET_W-1:0];
          if (last) begin
            state <= vdec_pkg::EC_IDLE;
          end
        end
        default: begin
          state <= vdec_pkg::EC_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/offset_gen.sv
// vs2 and vd offset selection, lane write enables and slide fill flags
`timescale 1ns/100ps
`default_nettype none

module offset_gen (
  input  vdec_pkg::offset_t    offset,
  input  vdec_pkg::offset_t    vl,
  input  vdec_pkg::offset_t    vstart,
  input  vdec_pkg::word_t      xs1,
  input  vdec_pkg::imm5_t      imm5,
  input  vdec_pkg::vs2_src_t   vs2_src,
  input  vdec_pkg::vd_src_t    vd_src,
  input  logic                 vm,
  input  logic [1:0]           v0_mask,
  output vdec_pkg::offset_t    vs2_offset0,
  output vdec_pkg::offset_t    vs2_offset1,
  output vdec_pkg::offset_t    vd_offset0,
  output vdec_pkg::offset_t    vd_offset1,
  output logic [1:0]           wen,
  output logic [1:0]           fill
);

  vdec_pkg::offset_t rs1_off;
  vdec_pkg::offset_t uimm;
  vdec_pkg::offset_t lane1_idx;
  vdec_pkg::offset_t vs2_prev;

  // all index math wraps at OFFSET_W bits
  assign rs1_off   = xs1[vdec_pkg::OFFSET_W-1:0];
  assign uimm      = vdec_pkg::offset_t'(imm5);
  assign lane1_idx = offset + vdec_pkg::offset_t'(1);

  always_comb begin
    case (vs2_src)
      vdec_pkg::VS2_NORMAL:        vs2_offset0 = offset;
      vdec_pkg::VS2_IDX_PLUS_RS1:  vs2_offset0 = offset + rs1_off;
      vdec_pkg::VS2_IDX_PLUS_UIMM: vs2_offset0 = offset + uimm;
      vdec_pkg::VS2_IDX_PLUS_1:    vs2_offset0 = lane1_idx;
      vdec_pkg::VS2_IDX_MINUS_1:   vs2_offset0 = offset - vdec_pkg::offset_t'(1);
      vdec_pkg::VS2_RS1:           vs2_offset0 = rs1_off;
      vdec_pkg::VS2_UIMM:          vs2_offset0 = uimm;
      default:                     vs2_offset0 = '0;
    endcase
    // scalar and zero sources broadcast to both lanes
    case (vs2_src)
      vdec_pkg::VS2_RS1, vdec_pkg::VS2_UIMM, vdec_pkg::VS2_ZERO: vs2_offset1 = vs2_offset0;
      default: vs2_offset1 = vs2_offset0 + vdec_pkg::offset_t'(1);
    endcase
  end

  always_comb begin
    case (vd_src)
      vdec_pkg::VD_ZERO:          vd_offset0 = '0;
      vdec_pkg::VD_IDX_PLUS_RS1:  vd_offset0 = offset + rs1_off;
      vdec_pkg::VD_IDX_PLUS_UIMM: vd_offset0 = offset + uimm;
      vdec_pkg::VD_IDX_PLUS_1:    vd_offset0 = lane1_idx;
      default:                    vd_offset0 = offset;
    endcase
    vd_offset1 = (vd_src == vdec_pkg::VD_ZERO) ? '0 : vd_offset0 + vdec_pkg::offset_t'(1);
  end

  // tail and mask gating per lane
  assign wen[0] = (offset < vl) && (vm || v0_mask[0]);
  assign wen[1] = (lane1_idx < vl) && (vm || v0_mask[1]);

  // slide1down reads past vl, slide1up reads below vstart
  assign vs2_prev = vs2_offset0 + vdec_pkg::offset_t'(1);
  assign fill[0] = ((vs2_src == vdec_pkg::VS2_IDX_PLUS_1) && (vs2_offset0 == vl))
                || ((vs2_src == vdec_pkg::VS2_IDX_MINUS_1) && (vs2_prev == vstart));
  assign fill[1] = (vs2_src == vdec_pkg::VS2_IDX_PLUS_1) && (vs2_offset1 == vl);

endmodule

`default_nettype wire

//--- source/decode_execute_reg.sv
// decode to execute pipeline register with eew and immediate extension
`timescale 1ns/100ps
`default_nettype none

module decode_execute_reg (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  busy,
  input  logic                  last,
  input  logic                  is_signed,
  input  vdec_pkg::sew_t        sew,
  input  vdec_pkg::width_mode_t width_mode,
  input  vdec_pkg::imm5_t       imm5,
  input  vdec_pkg::vreg_t       vd,
  input  vdec_pkg::offset_t     vs2_offset0,
  input  vdec_pkg::offset_t     vs2_offset1,
  input  vdec_pkg::offset_t     vd_offset0,
  input  vdec_pkg::offset_t     vd_offset1,
  input  logic [1:0]            wen,
  input  logic [1:0]            fill,
  output logic                  ex_valid,
  output logic                  ex_last,
  output vdec_pkg::offset_t     ex_vs2_offset0,
  output vdec_pkg::offset_t     ex_vs2_offset1,
  output vdec_pkg::offset_t     ex_vd_offset0,
  output vdec_pkg::offset_t     ex_vd_offset1,
  output logic [1:0]            ex_wen,
  output logic [1:0]            ex_fill,
  output vdec_pkg::sew_t        ex_eew,
  output vdec_pkg::word_t       ex_imm,
  output vdec_pkg::vreg_t       ex_vd
);

  vdec_pkg::sew_t  eew;
  vdec_pkg::word_t imm;

  // widen saturates at SEW32, narrow floors at SEW8
  always_comb begin
    eew = sew;
    if (width_mode == vdec_pkg::WM_WIDEN) begin
      eew = (sew == vdec_pkg::SEW8) ? vdec_pkg::SEW16 : vdec_pkg::SEW32;
    end else if (width_mode == vdec_pkg::WM_NARROW) begin
      eew = (sew == vdec_pkg::SEW32) ? vdec_pkg::SEW16 : vdec_pkg::SEW8;
    end
  end

  assign imm = is_signed ? {{27{imm5[4]}}, imm5} : {27'd0, imm5};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid       <= 1'b0;
      ex_last        <= 1'b0;
      ex_vs2_offset0 <= '0;
      ex_vs2_offset1 <= '0;
      ex_vd_offset0  <= '0;
      ex_vd_offset1  <= '0;
      ex_wen         <= '0;
      ex_fill        <= '0;
      ex_eew         <= vdec_pkg::SEW8;
      ex_imm         <= '0;
      ex_vd          <= '0;
    end else if (flush) begin
      // flush beats stall and empties the stage
      ex_valid       <= 1'b0;
      ex_last        <= 1'b0;
      ex_vs2_offset0 <= '0;
      ex_vs2_offset1 <= '0;
      ex_vd_offset0  <= '0;
      ex_vd_offset1  <= '0;
      ex_wen         <= '0;
      ex_fill        <= '0;
      ex_eew         <= vdec_pkg::SEW8;
      ex_imm         <= '0;
      ex_vd          <= '0;
    end else if (!stall) begin
      ex_valid       <= busy;
      ex_last        <= last;
      ex_vs2_offset0 <= vs2_offset0;
      ex_vs2_offset1 <= vs2_offset1;
      ex_vd_offset0  <= vd_offset0;
      ex_vd_offset1  <= vd_offset1;
      ex_wen         <= wen;
      ex_fill        <= fill;
      ex_eew         <= eew;
      ex_imm         <= imm;
      ex_vd          <= vd;
    end
  end

endmodule

`default_nettype wire

//--- source/vdec_top.sv
// top level of the vector decode core with csr, counter, offsets and pipeline register
`timescale 1ns/100ps
`default_nettype none

module vdec_top (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  cfg_wen,
  input  vdec_pkg::sew_t        cfg_sew,
  input  vdec_pkg::lmul_t       cfg_lmul,
  input  vdec_pkg::word_t       cfg_avl,
  input  vdec_pkg::offset_t     cfg_vstart,
  input  logic                  start,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  vm,
  input  logic                  is_signed,
  input  vdec_pkg::vs2_src_t    vs2_src,
  input  vdec_pkg::vd_src_t     vd_src,
  input  vdec_pkg::width_mode_t width_mode,
  input  vdec_pkg::imm5_t       imm5,
  input  vdec_pkg::word_t       xs1,
  input  vdec_pkg::vreg_t       vd,
  input  logic [1:0]            v0_mask,
  output logic                  busy,
  output vdec_pkg::offset_t     vl,
  output logic                  ex_valid,
  output logic                  ex_last,
  output vdec_pkg::offset_t     ex_vs2_offset0,
  output vdec_pkg::offset_t     ex_vs2_offset1,
  output vdec_pkg::offset_t     ex_vd_offset0,
  output vdec_pkg::offset_t     ex_vd_offset1,
  output logic [1:0]            ex_wen,
  output logic [1:0]            ex_fill,
  output vdec_pkg::sew_t        ex_eew,
  output vdec_pkg::word_t       ex_imm,
  output vdec_pkg::vreg_t       ex_vd
);

  vdec_pkg::sew_t    sew;
  vdec_pkg::offset_t vstart;
  vdec_pkg::offset_t offset;
  logic              last;
  vdec_pkg::offset_t vs2_offset0;
  vdec_pkg::offset_t vs2_offset1;
  vdec_pkg::offset_t vd_offset0;
  vdec_pkg::offset_t vd_offset1;
  logic [1:0]        wen;
  logic [1:0]        fill;

  // lmul only feeds the vl clamp inside the csr
  vtype_csr csr (
    .CLK, .nRST, .cfg_wen, .busy, .cfg_sew, .cfg_lmul, .cfg_avl, .cfg_vstart,
    .sew, .lmul(), .vl, .vstart
  );

  element_counter counter (
    .CLK, .nRST, .start, .stall, .flush, .vl, .vstart, .busy, .last, .offset
  );

  offset_gen offsets (
    .offset, .vl, .vstart, .xs1, .imm5, .vs2_src, .vd_src, .vm, .v0_mask,
    .vs2_offset0, .vs2_offset1, .vd_offset0, .vd_offset1, .wen, .fill
  );

  decode_execute_reg de_reg (
    .CLK, .nRST, .stall, .flush, .busy, .last, .is_signed, .sew, .width_mode,
    .imm5, .vd, .vs2_offset0, .vs2_offset1, .vd_offset0, .vd_offset1, .wen, .fill,
    .ex_valid, .ex_last, .ex_vs2_offset0, .ex_vs2_offset1, .ex_vd_offset0,
    .ex_vd_offset1, .ex_wen, .ex_fill, .ex_eew, .ex_imm, .ex_vd
  );

endmodule

`default_nettype wire

//--- test/vdec_asserts.sv
// concurrent checks of the vdec_top outputs against the testbench reference model
`timescale 1ns/100ps
`default_nettype none

module vdec_asserts (
  input logic              CLK,
  input logic              nRST,
  input logic              flush,
  input logic              busy,
  input vdec_pkg::offset_t vl,
  input logic              ex_valid,
  input logic              ex_last,
  input vdec_pkg::offset_t ex_vs2_offset0,
  input vdec_pkg::offset_t ex_vs2_offset1,
  input vdec_pkg::offset_t ex_vd_offset0,
  input vdec_pkg::offset_t ex_vd_offset1,
  input logic [1:0]        ex_wen,
  input logic [1:0]        ex_fill,
  input vdec_pkg::sew_t    ex_eew,
  input vdec_pkg::word_t   ex_imm,
  input vdec_pkg::vreg_t   ex_vd
);

  logic [32:0] pair;
  logic [3:0]  lane;
  logic [39:0] misc;

  assign pair = {ex_last, ex_vs2_offset0, ex_vs2_offset1, ex_vd_offset0, ex_vd_offset1};
  assign lane = {ex_wen, ex_fill};
  assign misc = {ex_eew, ex_imm, ex_vd};

  vl_rule: assert property (@(posedge CLK) disable iff (!nRST) vl == vdec_tb.m_vl)
    else begin
      $error("** Error vl_rule: expected %0d, actual %0d", $sampled(vdec_tb.m_vl), $sampled(vl));
      vdec_tb.assert_errors++;
    end

  busy_rule: assert property (@(posedge CLK) disable iff (!nRST) busy == vdec_tb.m_busy)
    else begin
      $error("** Error busy_rule: expected %0d, actual %0d", $sampled(vdec_tb.m_busy),
             $sampled(busy));
      vdec_tb.assert_errors++;
    end

  // one ex beat per presented pair, none after reset
  valid_rule: assert property (@(posedge CLK) disable iff (!nRST) ex_valid == vdec_tb.exp_valid)
    else begin
      $error("** Error valid_rule: expected %0d, actual %0d", $sampled(vdec_tb.exp_valid),
             $sampled(ex_valid));
      vdec_tb.assert_errors++;
    end

  // last flag, vs2 offsets and vd offsets
  pair_rule: assert property (@(posedge CLK) disable iff (!nRST)
    ex_valid |-> pair == vdec_tb.exp_pair)
    else begin
      $error("** Error pair_rule: expected %h, actual %h", $sampled(vdec_tb.exp_pair),
             $sampled(pair));
      vdec_tb.assert_errors++;
    end

  lane_rule: assert property (@(posedge CLK) disable iff (!nRST)
    ex_valid |-> lane == vdec_tb.exp_lane)
    else begin
      $error("** Error lane_rule: expected %h, actual %h", $sampled(vdec_tb.exp_lane),
             $sampled(lane));
      vdec_tb.assert_errors++;
    end

  // eew, extended immediate and destination register
  misc_rule: assert property (@(posedge CLK) disable iff (!nRST)
    ex_valid |-> misc == vdec_tb.exp_misc)
    else begin
      $error("** Error misc_rule: expected %h, actual %h", $sampled(vdec_tb.exp_misc),
             $sampled(misc));
      vdec_tb.assert_errors++;
    end

  flush_rule: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !ex_valid && !busy)
    else begin
      $error("flush_rule: ex_valid or busy still high the cycle after a flush");
      vdec_tb.assert_errors++;
    end

endmodule

`default_nettype wire

//--- test/vdec_tb.sv
// testbench for vdec_top with reference model, stimulus, watchdog and closing report
`timescale 1ns/100ps
`default_nettype none

module vdec_tb;

  localparam int RANDOM_SWEEPS = 24;
  localparam int NUM_SWEEPS    = 9 + RANDOM_SWEEPS;
  // config plus up to 64 pairs under random stall
  localparam int SWEEP_CYCLES  = 200;
  localparam int TIMEOUT_NS    = NUM_SWEEPS * SWEEP_CYCLES * 4 + 400;

  logic                  CLK;
  logic                  nRST;
  logic                  cfg_wen;
  vdec_pkg::sew_t        cfg_sew;
  vdec_pkg::lmul_t       cfg_lmul;
  vdec_pkg::word_t       cfg_avl;
  vdec_pkg::offset_t     cfg_vstart;
  logic                  start;
  logic                  stall;
  logic                  flush;
  logic                  vm;
  logic                  is_signed;
  vdec_pkg::vs2_src_t    vs2_src;
  vdec_pkg::vd_src_t     vd_src;
  vdec_pkg::width_mode_t width_mode;
  vdec_pkg::imm5_t       imm5;
  vdec_pkg::word_t       xs1;
  vdec_pkg::vreg_t       vd;
  logic [1:0]            v0_mask;
  logic                  busy;
  vdec_pkg::offset_t     vl;
  logic                  ex_valid;
  logic                  ex_last;
  vdec_pkg::offset_t     ex_vs2_offset0;
  vdec_pkg::offset_t     ex_vs2_offset1;
  vdec_pkg::offset_t     ex_vd_offset0;
  vdec_pkg::offset_t     ex_vd_offset1;
  logic [1:0]            ex_wen;
  logic [1:0]            ex_fill;
  vdec_pkg::sew_t        ex_eew;
  vdec_pkg::word_t       ex_imm;
  vdec_pkg::vreg_t       ex_vd;

  int                    seed;
  int                    errors = 0;
  int                    assert_errors = 0;
  int                    pulses;
  // reference model state and expected ex stage contents
  vdec_pkg::sew_t        m_sew;
  vdec_pkg::offset_t     m_vl;
  vdec_pkg::offset_t     m_vstart;
  vdec_pkg::offset_t     m_off;
  logic                  m_busy;
  logic                  m_last;
  logic                  exp_valid;
  logic [32:0]           exp_pair;
  logic [3:0]            exp_lane;
  logic [39:0]           exp_misc;

  vdec_top uut (.*);

  bind vdec_top vdec_asserts chk (
    .CLK, .nRST, .flush, .busy, .vl, .ex_valid, .ex_last, .ex_vs2_offset0, .ex_vs2_offset1,
    .ex_vd_offset0, .ex_vd_offset1, .ex_wen, .ex_fill, .ex_eew, .ex_imm, .ex_vd
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // vl is AVL clamped to VLMAX of the new config
  function automatic vdec_pkg::offset_t clamp_vl(input vdec_pkg::sew_t s,
                                                 input vdec_pkg::lmul_t l,
                                                 input vdec_pkg::word_t avl);
    int vlmax;
    // VLEN in bits over SEW in bits, times LMUL
    vlmax = (vdec_pkg::VLENB * 8) / (8 << int'(s)) * (1 << int'(l));
    if (avl > vdec_pkg::word_t'(vlmax)) begin
      return vdec_pkg::offset_t'(vlmax);
    end
    return vdec_pkg::offset_t'(avl);
  endfunction

  function automatic vdec_pkg::offset_t vs2_ref(input int lane);
    int b;
    case (vs2_src)
      vdec_pkg::VS2_NORMAL:        b = int'(m_off) + lane;
      vdec_pkg::VS2_IDX_PLUS_RS1:  b = int'(m_off) + int'(xs1[7:0]) + lane;
      vdec_pkg::VS2_IDX_PLUS_UIMM: b = int'(m_off) + int'(imm5) + lane;
      vdec_pkg::VS2_IDX_PLUS_1:    b = int'(m_off) + 1 + lane;
      vdec_pkg::VS2_IDX_MINUS_1:   b = int'(m_off) - 1 + lane;
      vdec_pkg::VS2_RS1:           b = int'(xs1[7:0]);
      vdec_pkg::VS2_UIMM:          b = int'(imm5);
      default:                     b = 0;
    endcase
    return vdec_pkg::offset_t'(b);
  endfunction

  function automatic vdec_pkg::offset_t vd_ref(input int lane);
    int b;
    case (vd_src)
      vdec_pkg::VD_ZERO:          b = 0;
      vdec_pkg::VD_IDX_PLUS_RS1:  b = int'(m_off) + int'(xs1[7:0]) + lane;
      vdec_pkg::VD_IDX_PLUS_UIMM: b = int'(m_off) + int'(imm5) + lane;
      vdec_pkg::VD_IDX_PLUS_1:    b = int'(m_off) + 1 + lane;
      default:                    b = int'(m_off) + lane;
    endcase
    return vdec_pkg::offset_t'(b);
  endfunction

  function automatic logic [1:0] wen_ref();
    logic [1:0] w;
    for (int i = 0; i < 2; i++) begin
      w[i] = (int'(m_off) + i < int'(m_vl)) && (vm || v0_mask[i]);
    end
    return w;
  endfunction

  // slide fill at the vl and vstart edges
  function automatic logic [1:0] fill_ref();
    logic [1:0] f;
    f = 2'b00;
    if (vs2_src == vdec_pkg::VS2_IDX_PLUS_1) begin
      f[0] = (vs2_ref(0) == m_vl);
      f[1] = (vs2_ref(1) == m_vl);
    end else if (vs2_src == vdec_pkg::VS2_IDX_MINUS_1) begin
      f[0] = (vdec_pkg::offset_t'(int'(vs2_ref(0)) + 1) == m_vstart);
    end
    return f;
  endfunction

  function automatic vdec_pkg::sew_t eew_ref();
    int s;
    s = int'(m_sew);
    if (width_mode == vdec_pkg::WM_WIDEN && s < 2) begin
      s = s + 1;
    end else if (width_mode == vdec_pkg::WM_NARROW && s > 0) begin
      s = s - 1;
    end
    return vdec_pkg::sew_t'(s);
  endfunction

  function automatic vdec_pkg::word_t imm_ref();
    if (is_signed) begin
      return 32'(signed'(imm5));
    end
    return 32'(imm5);
  endfunction

  assign m_last = m_busy && (int'(m_off) + 2 >= int'(m_vl));

  // config register and pair counter model
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      m_sew    <= vdec_pkg::SEW8;
      m_vl     <= '0;
      m_vstart <= '0;
      m_busy   <= 1'b0;
      m_off    <= '0;
    end else begin
      if (cfg_wen && !m_busy) begin
        m_sew    <= cfg_sew;
        m_vl     <= clamp_vl(cfg_sew, cfg_lmul, cfg_avl);
        m_vstart <= cfg_vstart;
      end
      if (flush) begin
        m_busy <= 1'b0;
        m_off  <= '0;
      end else if (!stall) begin
        if (!m_busy && start && (m_vstart < m_vl)) begin
          m_busy <= 1'b1;
          m_off  <= m_vstart;
        end else if (m_busy) begin
          m_off <= m_off + 8'd2;
          if (m_last) begin
            m_busy <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exp_valid <= 1'b0;
    end else if (flush) begin
      exp_valid <= 1'b0;
    end else if (!stall) begin
      exp_valid <= m_busy;
    end
  end

  // expected ex stage fields, captured on every unstalled edge
  always_ff @(posedge CLK) begin
    if (!stall) begin
      exp_pair <= {m_last, vs2_ref(0), vs2_ref(1), vd_ref(0), vd_ref(1)};
      exp_lane <= {wen_ref(), fill_ref()};
      exp_misc <= {eew_ref(), imm_ref(), vd};
    end
  end

  // a pair leaves the ex stage on an unstalled edge
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pulses <= 0;
    end else if (ex_valid && !stall) begin
      pulses <= pulses + 1;
    end
  end

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic configure(input int s, input int l, input int avl, input int vs);
    cfg_sew    = vdec_pkg::sew_t'(s);
    cfg_lmul   = vdec_pkg::lmul_t'(l);
    cfg_avl    = vdec_pkg::word_t'(avl);
    cfg_vstart = vdec_pkg::offset_t'(vs);
    cfg_wen    = 1'b1;
    step();
    cfg_wen = 1'b0;
  endtask

  task automatic run_sweep(input int mode, input int stall_pct, input int flush_at);
    int cyc;
    int base;
    int want;
    vs2_src    = vdec_pkg::vs2_src_t'(mode % 8);
    vd_src     = vdec_pkg::vd_src_t'(mode % 5);
    width_mode = vdec_pkg::width_mode_t'(mode % 3);
    vm         = 1'(pick(2));
    is_signed  = 1'(pick(2));
    imm5       = 5'(pick(32));
    xs1        = $random(seed);
    vd         = 5'(pick(32));
    v0_mask    = 2'(pick(4));
    want = (m_vl > m_vstart) ? (int'(m_vl) - int'(m_vstart) + 1) / 2 : 0;
    base = pulses;
    start = 1'b1;
    step();
    start = 1'b0;
    cyc = 0;
    while (busy) begin
      stall   = (pick(100) < stall_pct);
      flush   = (cyc == flush_at);
      v0_mask = 2'(pick(4));
      // config writes during a sweep must be ignored
      cfg_wen = (cyc == 1);
      cfg_avl = vdec_pkg::word_t'(pick(150));
      cyc++;
      step();
    end
    stall   = 1'b0;
    flush   = 1'b0;
    cfg_wen = 1'b0;
    repeat (2) step();
    if (flush_at < 0 || flush_at >= cyc) begin
      assert (pulses - base == want) else begin
        $display("** Error sweep_count: expected %0d, actual %0d", want, pulses - base);
        errors++;
      end
    end
  endtask

  initial begin
    seed       = 32'ha124_0eef;
    nRST       = 1'b0;
    cfg_wen    = 1'b0;
    cfg_sew    = vdec_pkg::SEW8;
    cfg_lmul   = vdec_pkg::LMUL1;
    cfg_avl    = '0;
    cfg_vstart = '0;
    start      = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    vm         = 1'b1;
    is_signed  = 1'b0;
    vs2_src    = vdec_pkg::VS2_NORMAL;
    vd_src     = vdec_pkg::VD_NORMAL;
    width_mode = vdec_pkg::WM_SAME;
    imm5       = '0;
    xs1        = '0;
    vd         = '0;
    v0_mask    = 2'b00;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    step();
    // every sew with every width mode, every vs2 and vd offset mode
    for (int i = 0; i < 9; i++) begin
      configure(i / 3, pick(4), 8 + pick(150), pick(3));
      run_sweep(i, 0, -1);
    end
    // back pressure, an occasional flush, and some sweeps that are never accepted
    for (int i = 0; i < RANDOM_SWEEPS; i++) begin
      configure(pick(3), pick(4), pick(150), pick(6));
      run_sweep(pick(120), 30, (i % 6 == 5) ? 3 : -1);
    end
    $display("closing report: %0d assertion errors, %0d sweep count errors",
             assert_errors, errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the sweeps did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/vdec_pkg.sv
source/vtype_csr.sv
source/element_counter.sv
source/offset_gen.sv
source/decode_execute_reg.sv
source/vdec_top.sv
test/vdec_asserts.sv
test/vdec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the vdec testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module vdec_tb -f files.f -o vdec_sim
./obj_dir/vdec_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
